//--- common/hyper_pkg.sv
// HyperRAM controller shared definitions
package hyper_pkg;

  // ------------------------------------------------
  // Data path widths
  // ------------------------------------------------

  // Request address and data width
  localparam int DWORD_W = 32;
  // Command/address word, six bytes on the bus
  localparam int CA_W = 48;
  // One DDR lane of the 8-bit device
  localparam int PIN_W = 8;
  // Byte enables per dword
  localparam int BE_W = 4;

  // ------------------------------------------------
  // Transaction timing in controller clocks
  // ------------------------------------------------

  // Two bytes per clock, so 48 bits take three
  localparam int CA_CYCLES = 3;
  // One dword in two clocks
  localparam int DATA_CYCLES = 2;
  // Read beat counter width
  localparam int BEAT_W = $clog2(DATA_CYCLES);
  // Fixed latencies, picked by RWDS during the command
  localparam int LATENCY_1X = 6;
  localparam int LATENCY_2X = 12;
  // Wait counter width, covers LATENCY_2X
  localparam int LAT_W = 6;
  // Chip select tail after the last data clock
  localparam int CS_HOLD = 2;

  // ------------------------------------------------
  // Command/address bit positions
  // ------------------------------------------------

  // 1 = read, 0 = write
  localparam int CA_RW_BIT = 47;
  // 1 = register space, 0 = memory space
  localparam int CA_AS_BIT = 46;
  // 1 = linear burst, always set here
  localparam int CA_BURST_BIT = 45;

  // Sequencer states
  typedef enum logic [2:0] {
    IDLE,
    CMD,
    WAIT,
    DATA,
    READ,
    HOLD
  } seq_state_t;

endpackage

//--- run.sh
#!/bin/sh
# Build and run the HyperRAM controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f tb.f \
  --top-module tb_top \
  -o tb_sim

./obj_dir/tb_sim

//--- sequencer/hyper_read_capture.sv
// HyperRAM read data capture
`timescale 1ns/1ps

module hyper_read_capture (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          capture_en,
  // RWDS, registered second edge and live first edge
  input  logic                          rwds_in_q,
  input  logic                          rwds_in0,
  // Data, registered first edge and live second edge
  input  logic [hyper_pkg::PIN_W-1:0]   dq_in0_q,
  input  logic [hyper_pkg::PIN_W-1:0]   dq_in1,
  output logic                          capture_done,
  output logic                          rd_valid,
  output logic [hyper_pkg::DWORD_W-1:0] rd_data
);
  import hyper_pkg::*;

  logic               strobe;
  logic [BEAT_W-1:0]  beat_cnt;
  logic [DWORD_W-1:0] rd_sr;

  // Falling RWDS across the clock marks a byte pair
  assign strobe = capture_en && rwds_in_q && !rwds_in0;

  // ------------------------------------------------
  // Beat counting
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      beat_cnt     <= '0;
      capture_done <= 1'b0;
      rd_valid     <= 1'b0;
    end else begin
      capture_done <= 1'b0;
      // Result one clock behind done
      rd_valid     <= capture_done;
      if (!capture_en) begin
        beat_cnt <= '0;
      end else if (strobe) begin
        if (beat_cnt == BEAT_W'(DATA_CYCLES - 1)) begin
          // Four bytes in
          beat_cnt     <= '0;
          capture_done <= 1'b1;
        end else begin
          beat_cnt <= beat_cnt + 1'b1;
        end
      end
    end
  end

  // Assembly, most significant pair first
  always_ff @(posedge clk) begin
    if (strobe) begin
      rd_sr <= {rd_sr[DWORD_W-2*PIN_W-1:0], dq_in0_q, dq_in1};
    end
    if (capture_done) begin
      rd_data <= rd_sr;
    end
  end

endmodule

//--- sequencer/hyper_sequencer.sv
// HyperRAM transaction sequencer
`timescale 1ns/1ps

module hyper_sequencer (
  input  logic                          clk,
  input  logic                          reset,
  // Command from request stage
  input  logic                          cmd_valid,
  input  logic [hyper_pkg::CA_W-1:0]    cmd_ca,
  input  logic [hyper_pkg::DWORD_W-1:0] cmd_wdata,
  input  logic [hyper_pkg::BE_W-1:0]    cmd_mask,
  input  logic                          cmd_write,
  input  logic                          cmd_reg,
  output logic                          cmd_ready,
  // Registered RWDS, picks the latency
  input  logic                          rwds_in_q,
  // Pin side, before the IO flops
  output logic [hyper_pkg::PIN_W-1:0]   dq_edge0,
  output logic [hyper_pkg::PIN_W-1:0]   dq_edge1,
  output logic                          rwds_edge0,
  output logic                          rwds_edge1,
  output logic                          dq_oe_l_d,
  output logic                          rwds_oe_l_d,
  output logic                          cs_active,
  // Read capture control
  output logic                          capture_en,
  input  logic                          capture_done
);
  import hyper_pkg::*;

  seq_state_t          state;
  logic [LAT_W-1:0]    step_cnt;
  logic [LAT_W-1:0]    lat_load;
  logic                accept;
  logic                drive_phase;
  logic [CA_W-1:0]     ca_sr;
  logic [DWORD_W-1:0]  wdata_sr;
  logic [BE_W-1:0]     mask_sr;
  logic                write_q;
  logic                reg_q;

  assign cmd_ready = (state == IDLE);
  assign accept    = cmd_valid && cmd_ready;

  // Device asks for double latency by holding RWDS high
  assign lat_load = rwds_in_q ? LAT_W'(LATENCY_2X - 1) : LAT_W'(LATENCY_1X - 1);

  // ------------------------------------------------
  // State machine, one down counter for every phase
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      step_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (cmd_valid) begin
            state    <= CMD;
            step_cnt <= LAT_W'(CA_CYCLES - 1);
          end
        end
        CMD: begin
          if (step_cnt == '0) begin
            if (reg_q && write_q) begin
              // Register writes have zero latency
              state    <= DATA;
              step_cnt <= LAT_W'(DATA_CYCLES - 1);
            end else begin
              state    <= WAIT;
              step_cnt <= lat_load;
            end
          end else begin
            step_cnt <= step_cnt - 1'b1;
          end
        end
        WAIT: begin
          if (step_cnt != '0) begin
            step_cnt <= step_cnt - 1'b1;
          end else if (write_q) begin
            state    <= DATA;
            step_cnt <= LAT_W'(DATA_CYCLES - 1);
          end else begin
            state <= READ;
          end
        end
        DATA: begin
          if (step_cnt == '0) begin
            state    <= HOLD;
            step_cnt <= LAT_W'(CS_HOLD - 1);
          end else begin
            step_cnt <= step_cnt - 1'b1;
          end
        end
        // Length set by the device strobe
        READ: begin
          if (capture_done) begin
            state    <= HOLD;
            step_cnt <= LAT_W'(CS_HOLD - 1);
          end
        end
        HOLD: begin
          if (step_cnt == '0) begin
            state <= IDLE;
          end else begin
            step_cnt <= step_cnt - 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Shift registers, two bytes leave per clock
  always_ff @(posedge clk) begin
    if (accept) begin
      ca_sr    <= cmd_ca;
      wdata_sr <= cmd_wdata;
      mask_sr  <= cmd_mask;
      write_q  <= cmd_write;
      reg_q    <= cmd_reg;
    end else begin
      if (state == CMD) begin
        ca_sr <= {ca_sr[CA_W-2*PIN_W-1:0], {(2*PIN_W){1'b0}}};
      end
      if (state == DATA) begin
        wdata_sr <= {wdata_sr[DWORD_W-2*PIN_W-1:0], {(2*PIN_W){1'b0}}};
        mask_sr  <= {mask_sr[BE_W-3:0], 2'b00};
      end
    end
  end

  // ------------------------------------------------
  // Pin values
  // ------------------------------------------------
  always_comb begin
    dq_edge0   = '0;
    dq_edge1   = '0;
    rwds_edge0 = 1'b0;
    rwds_edge1 = 1'b0;
    case (state)
      CMD: begin
        dq_edge0 = ca_sr[CA_W-1 -: PIN_W];
        dq_edge1 = ca_sr[CA_W-PIN_W-1 -: PIN_W];
      end
      DATA: begin
        dq_edge0   = wdata_sr[DWORD_W-1 -: PIN_W];
        dq_edge1   = wdata_sr[DWORD_W-PIN_W-1 -: PIN_W];
        rwds_edge0 = mask_sr[BE_W-1];
        rwds_edge1 = mask_sr[BE_W-2];
      end
      default: ;
    endcase
  end

  // Writes own the bus through latency and data
  assign drive_phase = write_q && ((state == WAIT) || (state == DATA));
  // RWDS stays input during the command for latency sampling
  assign dq_oe_l_d   = !((state == CMD) || drive_phase);
  assign rwds_oe_l_d = !drive_phase;
  assign cs_active   = (state != IDLE);
  assign capture_en  = (state == READ);

endmodule

//--- source/hyper_io_regs.sv
// HyperRAM pin IO flops
`timescale 1ns/1ps

module hyper_io_regs (
  input  logic                        clk,
  // From sequencer
  input  logic [hyper_pkg::PIN_W-1:0] dq_edge1,
  input  logic                        rwds_edge1,
  input  logic                        dq_oe_l_d,
  input  logic                        rwds_oe_l_d,
  input  logic                        cs_active,
  // From the pins
  input  logic                        rwds_in1,
  input  logic [hyper_pkg::PIN_W-1:0] dq_in0,
  // To the DDR IO block
  output logic [hyper_pkg::PIN_W-1:0] dq_out1,
  output logic                        rwds_out1,
  output logic                        dq_oe_l,
  output logic                        rwds_oe_l,
  output logic                        ck_en,
  // To sequencer and capture
  output logic                        rwds_in_q,
  output logic [hyper_pkg::PIN_W-1:0] dq_in0_q
);

  // ------------------------------------------------
  // Output side
  // ------------------------------------------------

  // Second edge lags a clock, giving rising then falling order
  always_ff @(posedge clk) begin
    dq_out1   <= dq_edge1;
    rwds_out1 <= rwds_edge1;
    // Enables follow the delayed edge
    dq_oe_l   <= dq_oe_l_d;
    rwds_oe_l <= rwds_oe_l_d;
    // Device clock runs a clock behind chip select
    ck_en     <= cs_active;
  end

  // ------------------------------------------------
  // Input side
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    rwds_in_q <= rwds_in1;
    dq_in0_q  <= dq_in0;
  end

endmodule

//--- source/hyper_request.sv
// HyperRAM request stage
`timescale 1ns/1ps

module hyper_request (
  input  logic                          clk,
  input  logic                          reset,
  // Request port
  input  logic                          req_valid,
  output logic                          req_ready,
  input  logic                          req_write,
  input  logic                          req_reg,
  input  logic [hyper_pkg::DWORD_W-1:0] req_addr,
  input  logic [hyper_pkg::DWORD_W-1:0] req_wdata,
  input  logic [hyper_pkg::BE_W-1:0]    req_byte_en,
  // Hand-off to sequencer
  output logic                          cmd_valid,
  output logic [hyper_pkg::CA_W-1:0]    cmd_ca,
  output logic [hyper_pkg::DWORD_W-1:0] cmd_wdata,
  output logic [hyper_pkg::BE_W-1:0]    cmd_mask,
  output logic                          cmd_write,
  output logic                          cmd_reg,
  input  logic                          cmd_ready
);
  import hyper_pkg::*;

  logic              accept;
  logic [CA_W-1:0]   ca_pack;

  // Single entry, so ready only while empty
  assign req_ready = !cmd_valid;
  assign accept    = req_valid && req_ready;

  // ------------------------------------------------
  // Command/address packing
  // ------------------------------------------------
  always_comb begin
    ca_pack = '0;
    // Read flag is the inverse of write
    ca_pack[CA_RW_BIT]    = !req_write;
    ca_pack[CA_AS_BIT]    = req_reg;
    ca_pack[CA_BURST_BIT] = 1'b1;
    if (req_reg) begin
      // Register space keeps the 16-bit word address
      ca_pack[CA_BURST_BIT-1:16] = req_addr[31:3];
      ca_pack[2:0]               = req_addr[2:0];
    end else begin
      // Memory space, always a dword aligned pair of half-words
      ca_pack[CA_BURST_BIT-1:16] = req_addr[30:2];
      ca_pack[2:0]               = {req_addr[1:0], 1'b0};
    end
    // Bits 15..3 reserved, left at zero
  end

  // Entry occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_valid <= 1'b0;
    end else if (accept) begin
      cmd_valid <= 1'b1;
    end else if (cmd_ready) begin
      // Sequencer took it
      cmd_valid <= 1'b0;
    end
  end

  // Held fields, loaded on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_ca    <= ca_pack;
      cmd_wdata <= req_wdata;
      // RWDS high masks a byte
      cmd_mask  <= ~req_byte_en;
      cmd_write <= req_write;
      cmd_reg   <= req_reg;
    end
  end

endmodule

//--- source/hyper_xface_top.sv
// HyperRAM controller top level
`timescale 1ns/1ps

module hyper_xface_top (
  input  logic                          clk,
  input  logic                          reset,
  // Request port
  input  logic                          req_valid,
  output logic                          req_ready,
  input  logic                          req_write,
  input  logic                          req_reg,
  input  logic [hyper_pkg::DWORD_W-1:0] req_addr,
  input  logic [hyper_pkg::DWORD_W-1:0] req_wdata,
  input  logic [hyper_pkg::BE_W-1:0]    req_byte_en,
  // Read result
  output logic                          rd_valid,
  output logic [hyper_pkg::DWORD_W-1:0] rd_data,
  // Device DDR pin pairs
  output logic [hyper_pkg::PIN_W-1:0]   dq_out0,
  output logic [hyper_pkg::PIN_W-1:0]   dq_out1,
  input  logic [hyper_pkg::PIN_W-1:0]   dq_in0,
  input  logic [hyper_pkg::PIN_W-1:0]   dq_in1,
  output logic                          dq_oe_l,
  output logic                          rwds_out0,
  output logic                          rwds_out1,
  input  logic                          rwds_in0,
  input  logic                          rwds_in1,
  output logic                          rwds_oe_l,
  output logic                          cs_l,
  output logic                          ck_en,
  output logic                          dram_rst_l
);
  import hyper_pkg::*;

  // Request to sequencer
  logic               cmd_valid;
  logic               cmd_ready;
  logic [CA_W-1:0]    cmd_ca;
  logic [DWORD_W-1:0] cmd_wdata;
  logic [BE_W-1:0]    cmd_mask;
  logic               cmd_write;
  logic               cmd_reg;
  // Sequencer to IO flops and capture
  logic [PIN_W-1:0]   dq_edge1;
  logic               rwds_edge1;
  logic               dq_oe_l_d;
  logic               rwds_oe_l_d;
  logic               cs_active;
  logic               capture_en;
  logic               capture_done;
  // Registered pin inputs
  logic               rwds_in_q;
  logic [PIN_W-1:0]   dq_in0_q;

  // Chip select held off through reset
  assign cs_l       = reset ? 1'b1 : !cs_active;
  assign dram_rst_l = !reset;

  // ------------------------------------------------
  // Pipeline stages
  // ------------------------------------------------
  hyper_request u_request (
    .clk(clk), .reset(reset),
    .req_valid(req_valid), .req_ready(req_ready),
    .req_write(req_write), .req_reg(req_reg),
    .req_addr(req_addr), .req_wdata(req_wdata), .req_byte_en(req_byte_en),
    .cmd_valid(cmd_valid), .cmd_ca(cmd_ca), .cmd_wdata(cmd_wdata),
    .cmd_mask(cmd_mask), .cmd_write(cmd_write), .cmd_reg(cmd_reg),
    .cmd_ready(cmd_ready)
  );

  // First edge pins come straight from the sequencer
  hyper_sequencer u_sequencer (
    .clk(clk), .reset(reset),
    .cmd_valid(cmd_valid), .cmd_ca(cmd_ca), .cmd_wdata(cmd_wdata),
    .cmd_mask(cmd_mask), .cmd_write(cmd_write), .cmd_reg(cmd_reg),
    .cmd_ready(cmd_ready), .rwds_in_q(rwds_in_q),
    .dq_edge0(dq_out0), .dq_edge1(dq_edge1),
    .rwds_edge0(rwds_out0), .rwds_edge1(rwds_edge1),
    .dq_oe_l_d(dq_oe_l_d), .rwds_oe_l_d(rwds_oe_l_d), .cs_active(cs_active),
    .capture_en(capture_en), .capture_done(capture_done)
  );

  hyper_read_capture u_read_capture (
    .clk(clk), .reset(reset), .capture_en(capture_en),
    .rwds_in_q(rwds_in_q), .rwds_in0(rwds_in0),
    .dq_in0_q(dq_in0_q), .dq_in1(dq_in1),
    .capture_done(capture_done), .rd_valid(rd_valid), .rd_data(rd_data)
  );

  hyper_io_regs u_io_regs (
    .clk(clk), .dq_edge1(dq_edge1), .rwds_edge1(rwds_edge1),
    .dq_oe_l_d(dq_oe_l_d), .rwds_oe_l_d(rwds_oe_l_d), .cs_active(cs_active),
    .rwds_in1(rwds_in1), .dq_in0(dq_in0),
    .dq_out1(dq_out1), .rwds_out1(rwds_out1), .dq_oe_l(dq_oe_l),
    .rwds_oe_l(rwds_oe_l), .ck_en(ck_en),
    .rwds_in_q(rwds_in_q), .dq_in0_q(dq_in0_q)
  );

endmodule

//--- tb.f
common/hyper_pkg.sv
source/hyper_request.sv
sequencer/hyper_sequencer.sv
sequencer/hyper_read_capture.sv
source/hyper_io_regs.sv
source/hyper_xface_top.sv
verification/tb_clock.sv
verification/hyper_ram_model.sv
verification/tb_top.sv

//--- verification/hyper_ram_model.sv
// Behavioral HyperRAM device
`timescale 1ns/1ps

module hyper_ram_model (
  input  logic                          clk,
  // Ask for double latency during the command
  input  logic                          latency_2x,
  // Controller pins
  input  logic                          cs_l,
  input  logic [hyper_pkg::PIN_W-1:0]   dq_out0,
  input  logic [hyper_pkg::PIN_W-1:0]   dq_out1,
  input  logic                          rwds_out0,
  input  logic                          rwds_out1,
  output logic [hyper_pkg::PIN_W-1:0]   dq_in0,
  output logic [hyper_pkg::PIN_W-1:0]   dq_in1,
  output logic                          rwds_in0,
  output logic                          rwds_in1,
  // Decoded command/address word, one clock pulse
  output logic                          ca_valid,
  output logic [hyper_pkg::CA_W-1:0]    ca_word
);
  import hyper_pkg::*;

  logic [DWORD_W-1:0] mem [16];
  logic [15:0]        regs [2];
  // Clocks since chip select fell
  int                 cnt;
  int                 lat_q;
  logic               rd_q;
  logic [CA_W-1:0]    ca_sr;
  logic [DWORD_W-1:0] wr_word;
  logic [BE_W-1:0]    wr_mask;
  logic [DWORD_W-1:0] rd_word;

  // Fill pattern covers every address bit
  initial begin
    logic [7:0] a;
    for (int i = 0; i < 16; i++) begin
      a = 8'(i);
      mem[i] = {a ^ 8'h5a, a, ~a, a + 8'h11};
    end
    regs[0]  = 16'h8f1f;
    regs[1]  = 16'h0002;
    cnt      = 0;
    lat_q    = 0;
    rd_q     = 1'b0;
    ca_sr    = '0;
    ca_valid = 1'b0;
    ca_word  = '0;
    rd_word  = '0;
  end

  // --------------------------------------------------
  // Pin decode, sampled at every rising edge
  // --------------------------------------------------
  always @(posedge clk) begin
    logic [CA_W-1:0] ca_full;
    ca_valid <= 1'b0;
    if (cs_l) begin
      cnt  <= 0;
      rd_q <= 1'b0;
    end else begin
      cnt <= cnt + 1;
      ca_full = ca_sr;
      // First edge byte now, second edge byte one clock later
      case (cnt)
        0: begin
          ca_full[47:40] = dq_out0;
          rd_q <= dq_out0[7];
          // Register writes skip the latency
          if (!dq_out0[7] && dq_out0[6]) lat_q <= 0;
          else lat_q <= latency_2x ? LATENCY_2X : LATENCY_1X;
        end
        1: begin
          ca_full[39:32] = dq_out1;
          ca_full[31:24] = dq_out0;
        end
        2: begin
          ca_full[23:16] = dq_out1;
          ca_full[15:8]  = dq_out0;
        end
        3: begin
          ca_full[7:0] = dq_out1;
          ca_valid <= 1'b1;
          ca_word  <= ca_full;
          // Read source picked once the address is complete
          if (ca_full[46]) rd_word <= {regs[ca_full[0]], regs[ca_full[0]]};
          else rd_word <= mem[ca_full[19:16]];
        end
        default: ;
      endcase
      ca_sr <= ca_full;
      // Write data and RWDS mask, same edge order as the command
      if (!rd_q && cnt == CA_CYCLES + lat_q) begin
        wr_word[31:24] = dq_out0;
        wr_mask[3]     = rwds_out0;
      end
      if (!rd_q && cnt == CA_CYCLES + lat_q + 1) begin
        wr_word[23:16] = dq_out1;
        wr_mask[2]     = rwds_out1;
        wr_word[15:8]  = dq_out0;
        wr_mask[1]     = rwds_out0;
      end
      if (!rd_q && cnt == CA_CYCLES + lat_q + 2) begin
        wr_word[7:0] = dq_out1;
        wr_mask[0]   = rwds_out1;
        if (ca_sr[46]) begin
          // Registers take the first 16 bits, no mask
          regs[ca_sr[0]] = wr_word[31:16];
        end else begin
          for (int b = 0; b < BE_W; b++) begin
            if (!wr_mask[b]) mem[ca_sr[19:16]][8*b +: 8] = wr_word[8*b +: 8];
          end
        end
      end
    end
  end

  // --------------------------------------------------
  // Device outputs
  // --------------------------------------------------
  always_comb begin
    dq_in0   = '0;
    dq_in1   = '0;
    rwds_in0 = 1'b0;
    rwds_in1 = 1'b0;
    if (!cs_l) begin
      // RWDS high through the command flags double latency
      if (latency_2x && cnt <= 2) begin
        rwds_in0 = 1'b1;
        rwds_in1 = 1'b1;
      end
      // One byte pair per two clocks, strobe falls between them
      if (rd_q) begin
        if (cnt == CA_CYCLES + lat_q) begin
          rwds_in0 = 1'b1;
          rwds_in1 = 1'b1;
          dq_in0   = rd_word[31:24];
        end
        if (cnt == CA_CYCLES + lat_q + 1) dq_in1 = rd_word[23:16];
        if (cnt == CA_CYCLES + lat_q + 2) begin
          rwds_in0 = 1'b1;
          rwds_in1 = 1'b1;
          dq_in0   = rd_word[15:8];
        end
        if (cnt == CA_CYCLES + lat_q + 3) dq_in1 = rd_word[7:0];
      end
    end
  end

endmodule

//--- verification/tb_clock.sv
// Testbench clock source
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  // 20 ns period
  initial begin
    clk = 1'b0;
  end

  always #10 clk = ~clk;

endmodule

//--- verification/tb_top.sv
// HyperRAM controller testbench
`timescale 1ns/1ps

module tb_top;
  import hyper_pkg::*;

  // 4 + 4 write/read pairs, 4 register accesses, 3 back to back
  localparam int TXN_TOTAL = 23;
  localparam int WATCHDOG_CLOCKS = 16 + 200 * TXN_TOTAL;

  logic               clk;
  logic               reset;
  logic               req_valid;
  logic               req_ready;
  logic               req_write;
  logic               req_reg;
  logic [DWORD_W-1:0] req_addr;
  logic [DWORD_W-1:0] req_wdata;
  logic [BE_W-1:0]    req_byte_en;
  logic               rd_valid;
  logic [DWORD_W-1:0] rd_data;
  logic [PIN_W-1:0]   dq_out0;
  logic [PIN_W-1:0]   dq_out1;
  logic [PIN_W-1:0]   dq_in0;
  logic [PIN_W-1:0]   dq_in1;
  logic               dq_oe_l;
  logic               rwds_out0;
  logic               rwds_out1;
  logic               rwds_in0;
  logic               rwds_in1;
  logic               rwds_oe_l;
  logic               cs_l;
  logic               ck_en;
  logic               dram_rst_l;
  logic               latency_2x;
  logic               ca_valid;
  logic [CA_W-1:0]    ca_word;

  int                 seed;
  int                 issued;
  int                 cs_windows;
  int                 low_cnt;
  int                 stall_cycles;
  // Expected device contents
  logic [DWORD_W-1:0] shadow_mem [16];
  logic [15:0]        shadow_reg [2];
  // Expected results, in issue order
  logic [CA_W-1:0]    exp_ca_q [$];
  int                 exp_len_q [$];
  logic [DWORD_W-1:0] exp_rd_q [$];
  logic [DWORD_W-1:0] exp_mask_q [$];

  tb_clock clock_gen (.clk(clk));

  hyper_xface_top dut0 (
    .clk(clk), .reset(reset),
    .req_valid(req_valid), .req_ready(req_ready),
    .req_write(req_write), .req_reg(req_reg),
    .req_addr(req_addr), .req_wdata(req_wdata), .req_byte_en(req_byte_en),
    .rd_valid(rd_valid), .rd_data(rd_data),
    .dq_out0(dq_out0), .dq_out1(dq_out1), .dq_in0(dq_in0), .dq_in1(dq_in1),
    .dq_oe_l(dq_oe_l), .rwds_out0(rwds_out0), .rwds_out1(rwds_out1),
    .rwds_in0(rwds_in0), .rwds_in1(rwds_in1), .rwds_oe_l(rwds_oe_l),
    .cs_l(cs_l), .ck_en(ck_en), .dram_rst_l(dram_rst_l)
  );

  hyper_ram_model ram0 (
    .clk(clk), .latency_2x(latency_2x), .cs_l(cs_l),
    .dq_out0(dq_out0), .dq_out1(dq_out1),
    .rwds_out0(rwds_out0), .rwds_out1(rwds_out1),
    .dq_in0(dq_in0), .dq_in1(dq_in1), .rwds_in0(rwds_in0), .rwds_in1(rwds_in1),
    .ca_valid(ca_valid), .ca_word(ca_word)
  );

  // --------------------------------------------------
  // Checking helpers
  // --------------------------------------------------
  task automatic stop_on_failure();
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [47:0] got,
                             input logic [47:0] exp);
    assert (got == exp) else begin
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  // Command/address word by the address mapping rules
  function automatic logic [CA_W-1:0] expected_ca(input logic write, input logic reg_sp,
                                                  input logic [DWORD_W-1:0] addr);
    logic [CA_W-1:0] ca;
    ca     = '0;
    ca[47] = !write;
    ca[46] = reg_sp;
    ca[45] = 1'b1;
    if (reg_sp) begin
      ca[44:16] = addr[31:3];
      ca[2:0]   = addr[2:0];
    end else begin
      ca[44:16] = addr[30:2];
      ca[2:0]   = {addr[1:0], 1'b0};
    end
    return ca;
  endfunction

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic send_req(input logic write, input logic reg_sp,
                          input logic [DWORD_W-1:0] addr, input logic [DWORD_W-1:0] wdata,
                          input logic [BE_W-1:0] be);
    int lat;
    req_valid   <= 1'b1;
    req_write   <= write;
    req_reg     <= reg_sp;
    req_addr    <= addr;
    req_wdata   <= wdata;
    req_byte_en <= be;
    @(posedge clk);
    // Fields stay put until accepted
    while (!req_ready) begin
      stall_cycles++;
      @(posedge clk);
    end
    req_valid <= 1'b0;
    issued++;
    exp_ca_q.push_back(expected_ca(write, reg_sp, addr));
    lat = latency_2x ? LATENCY_2X : LATENCY_1X;
    if (write && reg_sp) begin
      shadow_reg[addr[0]] = wdata[31:16];
      exp_len_q.push_back(CA_CYCLES + DATA_CYCLES + CS_HOLD);
    end else if (write) begin
      for (int b = 0; b < BE_W; b++) begin
        if (be[b]) shadow_mem[addr[5:2]][8*b +: 8] = wdata[8*b +: 8];
      end
      exp_len_q.push_back(CA_CYCLES + lat + DATA_CYCLES + CS_HOLD);
    end else begin
      // Read length follows the strobe, not checked
      exp_len_q.push_back(0);
      if (reg_sp) begin
        exp_rd_q.push_back({shadow_reg[addr[0]], 16'h0000});
        exp_mask_q.push_back(32'hffff_0000);
      end else begin
        exp_rd_q.push_back(shadow_mem[addr[5:2]]);
        exp_mask_q.push_back(32'hffff_ffff);
      end
    end
  endtask

  task automatic wait_done();
    while (cs_windows < issued) @(posedge clk);
  endtask

  // Random dword write then read back of the same address
  task automatic mem_write_read();
    logic [DWORD_W-1:0] addr;
    logic [DWORD_W-1:0] data;
    logic [DWORD_W-1:0] rnd;
    addr = $random(seed);
    addr[1:0] = 2'b00;
    data = $random(seed);
    rnd  = $random(seed);
    send_req(1'b1, 1'b0, addr, data, rnd[3:0]);
    send_req(1'b0, 1'b0, addr, '0, '0);
    wait_done();
  endtask

  // --------------------------------------------------
  // Monitors
  // --------------------------------------------------
  always @(posedge clk) begin
    if (ca_valid) begin
      if (exp_ca_q.size() == 0) begin
        $display("Error at %0t: device saw a command that was never requested", $time);
        stop_on_failure();
      end
      check_value("ca_word", ca_word, exp_ca_q[0]);
      void'(exp_ca_q.pop_front());
    end
  end

  // Chip select low time per transaction
  always @(posedge clk) begin
    if (reset) begin
      low_cnt <= 0;
    end else if (!cs_l) begin
      low_cnt <= low_cnt + 1;
    end else if (low_cnt != 0) begin
      if (exp_len_q.size() == 0) begin
        $display("Error at %0t: chip select window with no request behind it", $time);
        stop_on_failure();
      end
      if (exp_len_q[0] != 0) check_value("cs_l low clocks", 48'(low_cnt), 48'(exp_len_q[0]));
      void'(exp_len_q.pop_front());
      cs_windows <= cs_windows + 1;
      low_cnt    <= 0;
    end
  end

  always @(posedge clk) begin
    if (rd_valid) begin
      if (exp_rd_q.size() == 0) begin
        $display("Error at %0t: read data returned with no read pending", $time);
        stop_on_failure();
      end
      check_value("rd_data", 48'(rd_data & exp_mask_q[0]), 48'(exp_rd_q[0]));
      void'(exp_rd_q.pop_front());
      void'(exp_mask_q.pop_front());
    end
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CLOCKS) @(posedge clk);
    $display("Error: watchdog expired, transactions did not complete in time");
    stop_on_failure();
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    logic [7:0] a;
    seed         = 32'h1d4e_c4f6;
    reset        = 1'b1;
    req_valid    = 1'b0;
    req_write    = 1'b0;
    req_reg      = 1'b0;
    req_addr     = '0;
    req_wdata    = '0;
    req_byte_en  = '0;
    latency_2x   = 1'b0;
    issued       = 0;
    cs_windows   = 0;
    stall_cycles = 0;
    // Same fill as the device
    for (int i = 0; i < 16; i++) begin
      a = 8'(i);
      shadow_mem[i] = {a ^ 8'h5a, a, ~a, a + 8'h11};
    end
    repeat (16) @(posedge clk);
    // Device reset follows the controller reset
    check_value("dram_rst_l", 48'(dram_rst_l), 48'(0));
    reset <= 1'b0;
    repeat (2) @(posedge clk);

    // Idle pin levels
    check_value("cs_l", 48'(cs_l), 48'(1));
    check_value("dq_oe_l", 48'(dq_oe_l), 48'(1));
    check_value("rwds_oe_l", 48'(rwds_oe_l), 48'(1));
    check_value("ck_en", 48'(ck_en), 48'(0));
    check_value("rd_valid", 48'(rd_valid), 48'(0));
    check_value("req_ready", 48'(req_ready), 48'(1));
    check_value("dram_rst_l", 48'(dram_rst_l), 48'(1));

    // Single latency
    repeat (4) mem_write_read();
    // Double latency
    latency_2x <= 1'b1;
    @(posedge clk);
    repeat (4) mem_write_read();
    latency_2x <= 1'b0;
    @(posedge clk);

    // Register space, both registers
    send_req(1'b1, 1'b1, 32'h0000_1000, 32'h8f17_0000, 4'hf);
    send_req(1'b1, 1'b1, 32'h0000_1001, 32'h00c3_0000, 4'hf);
    send_req(1'b0, 1'b1, 32'h0000_1000, '0, '0);
    send_req(1'b0, 1'b1, 32'h0000_1001, '0, '0);
    wait_done();

    // Back to back, third request must wait for the entry
    stall_cycles = 0;
    send_req(1'b1, 1'b0, 32'h0000_0024, 32'hc0de_7e57, 4'b1010);
    send_req(1'b0, 1'b0, 32'h0000_0024, '0, '0);
    send_req(1'b0, 1'b0, 32'h0000_0038, '0, '0);
    wait_done();
    assert (stall_cycles > 0) else begin
      $display("Error: back to back request was never held off by req_ready");
      stop_on_failure();
    end
    assert (exp_rd_q.size() == 0) else begin
      $display("Error: some reads never returned data");
      stop_on_failure();
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule
